/* Bender.yml */
package:
  name: exe_stage

sources:
  - files:
      - hdl/exe_pkg.sv
      - hdl/exe_alu.sv
      - hdl/exe_mul.sv
      - hdl/exe_bypass.sv
      - hdl/exe_stage.sv
  - target: test
    files:
      - tb/exe_checker.sv
      - tb/exe_tb.sv

/* hdl/exe_alu.sv */
module exe_alu (
    input  exe_pkg::exe_op_e op,
    input  exe_pkg::data_t   src0,
    input  exe_pkg::data_t   src1,
    input  exe_pkg::data_t   imm,
    output exe_pkg::data_t   result
);
    import exe_pkg::*;

    logic [$clog2(DATA_W)-1:0] shamt;

    assign shamt = src1[$clog2(DATA_W)-1:0];

    always_comb begin
        case (op)
            OP_ADD:  result = src0 + src1;
            OP_SUB:  result = src0 - src1;
            OP_SLT: begin
                result = data_t'($signed(src0) < $signed(src1));
            end
            OP_SLTU: begin
                result = data_t'(src0 < src1);
            end
            OP_AND:  result = src0 & src1;
            OP_OR:   result = src0 | src1;
            OP_XOR:  result = src0 ^ src1;
            OP_NOR:  result = ~(src0 | src1);
            OP_SLL:  result = src0 << shamt;
            OP_SRL:  result = src0 >> shamt;
            OP_SRA: begin
                result = data_t'($signed(src0) >>> shamt);
            end
            // immediate arrives already shifted into place
            OP_LUI:  result = imm;
            // multiply ops are taken from the multiplier
            default: result = '0;
        endcase
    end

endmodule

/* hdl/exe_bypass.sv */
module exe_bypass (
    input  logic               eu0_en,
    input  logic               eu1_en,
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  exe_pkg::data_t     eu0_rdata0,
    input  exe_pkg::data_t     eu0_rdata1,
    input  exe_pkg::data_t     eu1_rdata0,
    input  exe_pkg::data_t     eu1_rdata1,
    input  logic               mid0_en,
    input  logic               mid1_en,
    input  exe_pkg::reg_addr_t mid0_rd,
    input  exe_pkg::reg_addr_t mid1_rd,
    input  exe_pkg::data_t     mid0_data,
    input  exe_pkg::data_t     mid1_data,
    input  logic               wb0_en,
    input  logic               wb1_en,
    input  exe_pkg::reg_addr_t wb0_rd,
    input  exe_pkg::reg_addr_t wb1_rd,
    input  exe_pkg::data_t     wb0_data,
    input  exe_pkg::data_t     wb1_data,
    input  logic               mul_busy,
    input  exe_pkg::reg_addr_t mul_busy_rd,
    output exe_pkg::data_t     eu0_src0,
    output exe_pkg::data_t     eu0_src1,
    output exe_pkg::data_t     eu1_src0,
    output exe_pkg::data_t     eu1_src1,
    output logic               stall
);
    import exe_pkg::*;

    // newest producer wins and lane 1 beats lane 0 within a pair
    function automatic data_t pick(input reg_addr_t addr, input data_t rf);
        data_t val;
        val = rf;
        if (addr != '0) begin
            if (mid1_en && mid1_rd == addr) begin
                val = mid1_data;
            end else if (mid0_en && mid0_rd == addr) begin
                val = mid0_data;
            end else if (wb1_en && wb1_rd == addr) begin
                val = wb1_data;
            end else if (wb0_en && wb0_rd == addr) begin
                val = wb0_data;
            end
        end
        return val;
    endfunction

    function automatic logic mul_hit(input logic en, input reg_addr_t addr);
        return en && addr != '0 && addr == mul_busy_rd;
    endfunction

    always_comb begin
        eu0_src0 = pick(eu0_rj, eu0_rdata0);
        eu0_src1 = pick(eu0_rk, eu0_rdata1);
        eu1_src0 = pick(eu1_rj, eu1_rdata0);
        eu1_src1 = pick(eu1_rk, eu1_rdata1);
    end

    // product not ready until it leaves the first multiplier stage
    always_comb begin
        stall = mul_busy && (mul_hit(eu0_en, eu0_rj) || mul_hit(eu0_en, eu0_rk)
                          || mul_hit(eu1_en, eu1_rj) || mul_hit(eu1_en, eu1_rk));
    end

endmodule

/* hdl/exe_mul.sv */
module exe_mul (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               en,
    input  exe_pkg::exe_op_e   op,
    input  exe_pkg::reg_addr_t rd,
    input  exe_pkg::data_t     src0,
    input  exe_pkg::data_t     src1,
    output exe_pkg::reg_addr_t busy_rd,
    output logic               busy,
    output logic               result_en,
    output exe_pkg::reg_addr_t result_rd,
    output exe_pkg::data_t     result
);
    import exe_pkg::*;

    half_t a_lo;
    half_t a_hi;
    half_t b_lo;
    half_t b_hi;
    data_t corr_next;

    // first stage register
    logic      s1_valid;
    exe_op_e   s1_op;
    reg_addr_t s1_rd;
    data_t     s1_pp_ll;
    data_t     s1_pp_lh;
    data_t     s1_pp_hl;
    data_t     s1_pp_hh;
    data_t     s1_corr;

    logic [2*DATA_W-1:0] prod;
    data_t               prod_hi;

    assign a_lo = src0[HALF_W-1:0];
    assign a_hi = src0[DATA_W-1:HALF_W];
    assign b_lo = src1[HALF_W-1:0];
    assign b_hi = src1[DATA_W-1:HALF_W];

    // signed high word = unsigned high word minus these two terms
    always_comb begin
        corr_next = '0;
        if (op == OP_MULH) begin
            corr_next = (src0[DATA_W-1] ? src1 : '0) + (src1[DATA_W-1] ? src0 : '0);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= en;
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            s1_op    <= op;
            s1_rd    <= rd;
            s1_pp_ll <= data_t'(a_lo) * data_t'(b_lo);
            s1_pp_lh <= data_t'(a_lo) * data_t'(b_hi);
            s1_pp_hl <= data_t'(a_hi) * data_t'(b_lo);
            s1_pp_hh <= data_t'(a_hi) * data_t'(b_hi);
            s1_corr  <= corr_next;
        end
    end

    // cross terms of the second stage sit one half word up
    assign prod = {s1_pp_hh, s1_pp_ll}
                + {{HALF_W{1'b0}}, s1_pp_lh, {HALF_W{1'b0}}}
                + {{HALF_W{1'b0}}, s1_pp_hl, {HALF_W{1'b0}}};

    assign prod_hi = prod[2*DATA_W-1:DATA_W] - s1_corr;

    assign result    = (s1_op == OP_MUL) ? prod[DATA_W-1:0] : prod_hi;
    assign result_en = s1_valid;
    assign result_rd = s1_rd;
    assign busy      = s1_valid;
    assign busy_rd   = s1_rd;

endmodule

/* hdl/exe_pkg.sv */
package exe_pkg;

    localparam int DATA_W     = 32;
    localparam int HALF_W     = 16;
    localparam int REG_ADDR_W = 5;
    localparam int OP_W       = 4;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [HALF_W-1:0]     half_t;

    // lane 1 only ever sees the ALU subset
    typedef enum logic [OP_W-1:0] {
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_MUL,
        OP_MULH,
        OP_MULHU
    } exe_op_e;

endpackage

/* hdl/exe_stage.sv */
module exe_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               eu0_en,
    input  exe_pkg::exe_op_e   eu0_op,
    input  logic               eu0_src2_imm,
    input  exe_pkg::reg_addr_t eu0_rd,
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::data_t     eu0_imm,
    input  exe_pkg::data_t     eu0_rdata0,
    input  exe_pkg::data_t     eu0_rdata1,
    input  logic               eu1_en,
    input  exe_pkg::exe_op_e   eu1_op,
    input  logic               eu1_src2_imm,
    input  exe_pkg::reg_addr_t eu1_rd,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  exe_pkg::data_t     eu1_imm,
    input  exe_pkg::data_t     eu1_rdata0,
    input  exe_pkg::data_t     eu1_rdata1,
    output logic               stall,
    output logic               en_out0,
    output logic               en_out1,
    output exe_pkg::reg_addr_t addr_out0,
    output exe_pkg::reg_addr_t addr_out1,
    output exe_pkg::data_t     data_out0,
    output exe_pkg::data_t     data_out1
);
    import exe_pkg::*;

    data_t     eu0_src0;
    data_t     eu0_src1;
    data_t     eu1_src0;
    data_t     eu1_src1;
    data_t     eu0_opb;
    data_t     eu1_opb;
    logic      eu0_is_mul;
    data_t     alu0_result;
    data_t     alu1_result;

    logic      mul_busy;
    reg_addr_t mul_busy_rd;
    logic      mul_result_en;
    reg_addr_t mul_result_rd;
    data_t     mul_result;

    // middle stage holds ALU results only
    logic      mid0_en;
    logic      mid1_en;
    reg_addr_t mid0_rd;
    reg_addr_t mid1_rd;
    data_t     mid0_data;
    data_t     mid1_data;

    assign eu0_is_mul = eu0_op inside {OP_MUL, OP_MULH, OP_MULHU};
    assign eu0_opb    = eu0_src2_imm ? eu0_imm : eu0_src1;
    assign eu1_opb    = eu1_src2_imm ? eu1_imm : eu1_src1;

    exe_bypass u_bypass (
        .eu0_en      (eu0_en),
        .eu1_en      (eu1_en),
        .eu0_rj      (eu0_rj),
        .eu0_rk      (eu0_rk),
        .eu1_rj      (eu1_rj),
        .eu1_rk      (eu1_rk),
        .eu0_rdata0  (eu0_rdata0),
        .eu0_rdata1  (eu0_rdata1),
        .eu1_rdata0  (eu1_rdata0),
        .eu1_rdata1  (eu1_rdata1),
        .mid0_en     (mid0_en),
        .mid1_en     (mid1_en),
        .mid0_rd     (mid0_rd),
        .mid1_rd     (mid1_rd),
        .mid0_data   (mid0_data),
        .mid1_data   (mid1_data),
        .wb0_en      (en_out0),
        .wb1_en      (en_out1),
        .wb0_rd      (addr_out0),
        .wb1_rd      (addr_out1),
        .wb0_data    (data_out0),
        .wb1_data    (data_out1),
        .mul_busy    (mul_busy),
        .mul_busy_rd (mul_busy_rd),
        .eu0_src0    (eu0_src0),
        .eu0_src1    (eu0_src1),
        .eu1_src0    (eu1_src0),
        .eu1_src1    (eu1_src1),
        .stall       (stall)
    );

    exe_alu u_alu0 (
        .op     (eu0_op),
        .src0   (eu0_src0),
        .src1   (eu0_opb),
        .imm    (eu0_imm),
        .result (alu0_result)
    );

    exe_alu u_alu1 (
        .op     (eu1_op),
        .src0   (eu1_src0),
        .src1   (eu1_opb),
        .imm    (eu1_imm),
        .result (alu1_result)
    );

    exe_mul u_mul (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (eu0_en && eu0_is_mul && !stall),
        .op        (eu0_op),
        .rd        (eu0_rd),
        .src0      (eu0_src0),
        .src1      (eu0_src1),
        .busy_rd   (mul_busy_rd),
        .busy      (mul_busy),
        .result_en (mul_result_en),
        .result_rd (mul_result_rd),
        .result    (mul_result)
    );

    // bubble into the middle stage while stalled
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid0_en <= 1'b0;
            mid1_en <= 1'b0;
            en_out0 <= 1'b0;
            en_out1 <= 1'b0;
        end else begin
            mid0_en <= eu0_en && !eu0_is_mul && !stall;
            mid1_en <= eu1_en && !stall;
            en_out0 <= mid0_en || mul_result_en;
            en_out1 <= mid1_en;
        end
    end

    always_ff @(posedge clk) begin
        mid0_rd   <= eu0_rd;
        mid0_data <= alu0_result;
        mid1_rd   <= eu1_rd;
        mid1_data <= alu1_result;
        // lane 0 never holds an ALU op and a multiply at once
        if (mul_result_en) begin
            addr_out0 <= mul_result_rd;
            data_out0 <= mul_result;
        end else begin
            addr_out0 <= mid0_rd;
            data_out0 <= mid0_data;
        end
        addr_out1 <= mid1_rd;
        data_out1 <= mid1_data;
    end

endmodule

/* src.f */
hdl/exe_pkg.sv
hdl/exe_alu.sv
hdl/exe_mul.sv
hdl/exe_bypass.sv
hdl/exe_stage.sv
tb/exe_checker.sv
tb/exe_tb.sv

/* tb/exe_checker.sv */
module exe_checker (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               eu0_en,
    input  exe_pkg::exe_op_e   eu0_op,
    input  logic               eu0_src2_imm,
    input  exe_pkg::reg_addr_t eu0_rd,
    input  exe_pkg::reg_addr_t eu0_rj,
    input  exe_pkg::reg_addr_t eu0_rk,
    input  exe_pkg::data_t     eu0_imm,
    input  logic               eu1_en,
    input  exe_pkg::exe_op_e   eu1_op,
    input  logic               eu1_src2_imm,
    input  exe_pkg::reg_addr_t eu1_rd,
    input  exe_pkg::reg_addr_t eu1_rj,
    input  exe_pkg::reg_addr_t eu1_rk,
    input  exe_pkg::data_t     eu1_imm,
    input  logic               stall,
    input  logic               en_out0,
    input  logic               en_out1,
    input  exe_pkg::reg_addr_t addr_out0,
    input  exe_pkg::reg_addr_t addr_out1,
    input  exe_pkg::data_t     data_out0,
    input  exe_pkg::data_t     data_out1,
    output int                 error_count,
    output int                 missing
);
    import exe_pkg::*;

    typedef struct packed {
        logic [31:0] due;
        reg_addr_t   addr;
        data_t       data;
    } result_t;

    data_t     arch [32];
    result_t   exp_q0 [$];
    result_t   exp_q1 [$];
    int        cycle;
    int        missed;
    logic      mul_pend;
    reg_addr_t mul_rd;
    logic      exp_stall;

    initial begin
        error_count = 0;
        missing     = 0;
        missed      = 0;
        cycle       = 0;
        mul_pend    = 1'b0;
        mul_rd      = '0;
        for (int r = 0; r < 32; r++) begin
            arch[r] = '0;
        end
    end

    function automatic data_t read_arch(input reg_addr_t r);
        return (r == '0) ? '0 : arch[r];
    endfunction

    function automatic data_t ref_result(input exe_op_e op, input data_t a, input data_t b,
                                         input data_t imm);
        longint      sa;
        longint      sb;
        longint      sprod;
        logic [63:0] uprod;
        data_t       result;
        sa    = $signed(a);
        sb    = $signed(b);
        sprod = sa * sb;
        uprod = {32'd0, a} * {32'd0, b};
        case (op)
            OP_ADD:   result = a + b;
            OP_SUB:   result = a - b;
            OP_SLT:   result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            OP_SLTU:  result = (a < b) ? 32'd1 : 32'd0;
            OP_AND:   result = a & b;
            OP_OR:    result = a | b;
            OP_XOR:   result = a ^ b;
            OP_NOR:   result = ~(a | b);
            OP_SLL:   result = a << b[4:0];
            OP_SRL:   result = a >> b[4:0];
            OP_SRA:   result = $signed(a) >>> b[4:0];
            OP_LUI:   result = imm;
            OP_MUL:   result = uprod[31:0];
            OP_MULH:  result = sprod[63:32];
            OP_MULHU: result = uprod[63:32];
            default:  result = '0;
        endcase
        return result;
    endfunction

    // rk only counts as a read when no immediate is selected
    function automatic logic uses_reg(input logic en, input logic imm_sel, input reg_addr_t rj,
                                      input reg_addr_t rk, input reg_addr_t r);
        return en && r != '0 && (rj == r || (!imm_sel && rk == r));
    endfunction

    task automatic execute_lane(input int lane, input exe_op_e op, input logic imm_sel,
                                input reg_addr_t rd, input reg_addr_t rj, input reg_addr_t rk,
                                input data_t imm);
        data_t   val;
        result_t entry;
        val = ref_result(op, read_arch(rj), imm_sel ? imm : read_arch(rk), imm);
        arch[rd] = val;
        entry = '{due: cycle + 2, addr: rd, data: val};
        if (lane == 0) begin
            exp_q0.push_back(entry);
            if (op inside {OP_MUL, OP_MULH, OP_MULHU}) begin
                mul_pend = 1'b1;
                mul_rd   = rd;
            end
        end else begin
            exp_q1.push_back(entry);
        end
    endtask

    task automatic check_lane(input int lane, input logic en, input reg_addr_t addr,
                              input data_t data);
        logic    due_now;
        result_t front;
        due_now = 1'b0;
        if (lane == 0 && exp_q0.size() != 0 && exp_q0[0].due == cycle) begin
            due_now = 1'b1;
            front   = exp_q0.pop_front();
        end else if (lane == 1 && exp_q1.size() != 0 && exp_q1[0].due == cycle) begin
            due_now = 1'b1;
            front   = exp_q1.pop_front();
        end
        if (due_now) begin
            if (en !== 1'b1) begin
                missed++;
                $display("lane %0d result for r%0d did not appear at cycle %0d",
                         lane, front.addr, cycle);
            end else begin
                if (addr !== front.addr) begin
                    error_count++;
                    $display("MISMATCH addr_out%0d: expected %h, actual %h",
                             lane, front.addr, addr);
                end
                if (data !== front.data) begin
                    error_count++;
                    $display("MISMATCH data_out%0d: expected %h, actual %h",
                             lane, front.data, data);
                end
            end
        end else if (en !== 1'b0) begin
            error_count++;
            $display("lane %0d produced a result nobody issued at cycle %0d", lane, cycle);
        end
    endtask

    always @(posedge clk) begin
        check_lane(0, en_out0, addr_out0, data_out0);
        check_lane(1, en_out1, addr_out1, data_out1);
        // product still in the first multiplier stage
        exp_stall = mul_pend && (uses_reg(eu0_en, eu0_src2_imm, eu0_rj, eu0_rk, mul_rd)
                              || uses_reg(eu1_en, eu1_src2_imm, eu1_rj, eu1_rk, mul_rd));
        if (stall !== exp_stall) begin
            error_count++;
            $display("MISMATCH stall: expected %h, actual %h", exp_stall, stall);
        end
        mul_pend = 1'b0;
        if (arst_n && !stall && (eu0_en || eu1_en)) begin
            // program order with lane 0 first
            if (eu0_en) begin
                execute_lane(0, eu0_op, eu0_src2_imm, eu0_rd, eu0_rj, eu0_rk, eu0_imm);
            end
            if (eu1_en) begin
                execute_lane(1, eu1_op, eu1_src2_imm, eu1_rd, eu1_rj, eu1_rk, eu1_imm);
            end
        end
        missing = missed + exp_q0.size() + exp_q1.size();
        cycle++;
    end

endmodule

/* tb/exe_tb.sv */
module exe_tb;
    import exe_pkg::*;

    localparam int unsigned SEED    = 32'h7391d435;
    localparam int N_FILL           = 16;
    localparam int N_RAND           = 48;
    localparam int N_CHAIN          = 24;
    localparam int N_CORNER         = 3;
    localparam int N_MUL            = 6 * 6 * 3;
    localparam int N_USE            = 12;
    localparam int N_PAIRS          = N_FILL + N_RAND + N_CHAIN + N_CORNER + N_MUL + 2 * N_USE;
    localparam int TIMEOUT_CYCLES   = N_PAIRS * 4 + 100;

    logic      clk = 1'b0;
    logic      arst_n;
    logic      eu0_en;
    exe_op_e   eu0_op;
    logic      eu0_src2_imm;
    reg_addr_t eu0_rd;
    reg_addr_t eu0_rj;
    reg_addr_t eu0_rk;
    data_t     eu0_imm;
    data_t     eu0_rdata0;
    data_t     eu0_rdata1;
    logic      eu1_en;
    exe_op_e   eu1_op;
    logic      eu1_src2_imm;
    reg_addr_t eu1_rd;
    reg_addr_t eu1_rj;
    reg_addr_t eu1_rk;
    data_t     eu1_imm;
    data_t     eu1_rdata0;
    data_t     eu1_rdata1;
    logic      stall;
    logic      en_out0;
    logic      en_out1;
    reg_addr_t addr_out0;
    reg_addr_t addr_out1;
    data_t     data_out0;
    data_t     data_out1;

    data_t     regs [32];
    int        errors;
    int        missing;

    always #10 clk = ~clk;

    exe_stage dut (.*);

    exe_checker u_checker (
        .clk(clk), .arst_n(arst_n),
        .eu0_en(eu0_en), .eu0_op(eu0_op), .eu0_src2_imm(eu0_src2_imm), .eu0_rd(eu0_rd),
        .eu0_rj(eu0_rj), .eu0_rk(eu0_rk), .eu0_imm(eu0_imm),
        .eu1_en(eu1_en), .eu1_op(eu1_op), .eu1_src2_imm(eu1_src2_imm), .eu1_rd(eu1_rd),
        .eu1_rj(eu1_rj), .eu1_rk(eu1_rk), .eu1_imm(eu1_imm),
        .stall(stall), .en_out0(en_out0), .en_out1(en_out1),
        .addr_out0(addr_out0), .addr_out1(addr_out1),
        .data_out0(data_out0), .data_out1(data_out1),
        .error_count(errors), .missing(missing)
    );

    // lane 1 is written last so it wins in the architectural file
    initial begin
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
    end

    always @(posedge clk) begin
        if (en_out0) begin
            regs[addr_out0] <= data_out0;
        end
        if (en_out1) begin
            regs[addr_out1] <= data_out1;
        end
    end

    assign eu0_rdata0 = (eu0_rj == '0) ? '0 : regs[eu0_rj];
    assign eu0_rdata1 = (eu0_rk == '0) ? '0 : regs[eu0_rk];
    assign eu1_rdata0 = (eu1_rj == '0) ? '0 : regs[eu1_rj];
    assign eu1_rdata1 = (eu1_rk == '0) ? '0 : regs[eu1_rk];

    function automatic reg_addr_t random_reg();
        return reg_addr_t'($urandom % 32);
    endfunction

    // lane 1 must not read lane 0's destination of the same pair
    function automatic reg_addr_t avoid_rd(input reg_addr_t r, input reg_addr_t rd0);
        return (r == rd0 && r != '0) ? (r ^ 5'd1) : r;
    endfunction

    function automatic exe_op_e mul_op(input int k);
        case (k)
            0:       return OP_MUL;
            1:       return OP_MULH;
            default: return OP_MULHU;
        endcase
    endfunction

    task automatic drive_lane0(input exe_op_e op, input logic imm_sel, input reg_addr_t rd,
                               input reg_addr_t rj, input reg_addr_t rk, input data_t imm);
        eu0_en       <= 1'b1;
        eu0_op       <= op;
        eu0_src2_imm <= imm_sel;
        eu0_rd       <= rd;
        eu0_rj       <= rj;
        eu0_rk       <= imm_sel ? '0 : rk;
        eu0_imm      <= imm;
    endtask

    task automatic drive_lane1(input exe_op_e op, input logic imm_sel, input reg_addr_t rd,
                               input reg_addr_t rj, input reg_addr_t rk, input data_t imm);
        eu1_en       <= 1'b1;
        eu1_op       <= op;
        eu1_src2_imm <= imm_sel;
        eu1_rd       <= rd;
        eu1_rj       <= rj;
        eu1_rk       <= imm_sel ? '0 : rk;
        eu1_imm      <= imm;
    endtask

    // pair stays on the inputs until an edge without stall
    task automatic wait_accept();
        logic held;
        do begin
            @(negedge clk);
            held = stall;
            @(posedge clk);
        end while (held);
    endtask

    task automatic go_idle();
        eu0_en <= 1'b0;
        eu1_en <= 1'b0;
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int        n;
        reg_addr_t rd0;
        reg_addr_t rd1;
        reg_addr_t prev0;
        reg_addr_t prev1;
        data_t     corner [6];
        void'($urandom(SEED));
        arst_n       <= 1'b0;
        eu0_en       <= 1'b0;
        eu0_op       <= OP_ADD;
        eu0_src2_imm <= 1'b0;
        eu0_imm      <= '0;
        eu0_rd       <= '0;
        eu0_rj       <= '0;
        eu0_rk       <= '0;
        eu1_en       <= 1'b0;
        eu1_op       <= OP_ADD;
        eu1_src2_imm <= 1'b0;
        eu1_imm      <= '0;
        eu1_rd       <= '0;
        eu1_rj       <= '0;
        eu1_rk       <= '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);

        // r1..r31 get random values and the last write hits r0
        for (int i = 0; i < N_FILL; i++) begin
            drive_lane0(OP_LUI, 1'b1, reg_addr_t'(2 * i + 1), '0, '0, $urandom);
            drive_lane1(OP_LUI, 1'b1, reg_addr_t'(2 * i + 2), '0, '0, $urandom);
            wait_accept();
        end

        for (int i = 0; i < N_RAND; i++) begin
            rd0 = random_reg();
            drive_lane0(exe_op_e'(i % 12), 1'($urandom % 2), rd0, random_reg(), random_reg(),
                        $urandom);
            drive_lane1(exe_op_e'((i + 5) % 12), 1'($urandom % 2), random_reg(),
                        avoid_rd(random_reg(), rd0), avoid_rd(random_reg(), rd0), $urandom);
            wait_accept();
        end

        // each pair reads the previous one and every fourth writes one rd twice
        prev0 = 5'd5;
        prev1 = 5'd10;
        for (int i = 0; i < N_CHAIN; i++) begin
            rd0 = reg_addr_t'(5 + i % 3);
            rd1 = (i % 4 == 3) ? rd0 : reg_addr_t'(10 + i % 3);
            drive_lane0(exe_op_e'($urandom % 11), 1'b0, rd0, prev1, prev0, '0);
            drive_lane1(exe_op_e'($urandom % 11), 1'b0, rd1, avoid_rd(prev0, rd0),
                        avoid_rd((i % 5 == 0) ? 5'd0 : prev1, rd0), '0);
            prev0 = rd0;
            prev1 = rd1;
            wait_accept();
        end

        corner[0] = 32'h0000_0000;
        corner[1] = 32'h0000_0001;
        corner[2] = 32'hffff_ffff;
        corner[3] = 32'h8000_0000;
        corner[4] = $urandom;
        corner[5] = $urandom;
        for (int i = 0; i < N_CORNER; i++) begin
            drive_lane0(OP_LUI, 1'b1, reg_addr_t'(21 + 2 * i), '0, '0, corner[2 * i]);
            drive_lane1(OP_LUI, 1'b1, reg_addr_t'(22 + 2 * i), '0, '0, corner[2 * i + 1]);
            wait_accept();
        end

        // no pair here reads a multiply destination
        n = 0;
        for (int a = 0; a < 6; a++) begin
            for (int b = 0; b < 6; b++) begin
                for (int k = 0; k < 3; k++) begin
                    drive_lane0(mul_op(k), 1'b0, reg_addr_t'(27 + n % 4), reg_addr_t'(21 + a),
                                reg_addr_t'(21 + b), '0);
                    drive_lane1(exe_op_e'($urandom % 12), 1'($urandom % 2),
                                reg_addr_t'(1 + $urandom % 19), reg_addr_t'(1 + $urandom % 19),
                                reg_addr_t'(1 + $urandom % 19), $urandom);
                    n++;
                    wait_accept();
                end
            end
        end

        for (int i = 0; i < N_USE; i++) begin
            rd0 = reg_addr_t'(27 + i % 3);
            drive_lane0(mul_op(i % 3), 1'b0, rd0, reg_addr_t'(21 + $urandom % 6),
                        reg_addr_t'(21 + $urandom % 6), '0);
            drive_lane1(OP_XOR, 1'b0, 5'd15, 5'd3, 5'd4, '0);
            wait_accept();
            if (i % 2 == 0) begin
                drive_lane0(OP_ADD, 1'b0, 5'd16, rd0, 5'd22, '0);
                drive_lane1(OP_OR, 1'b0, 5'd17, 5'd1, 5'd2, '0);
            end else begin
                drive_lane0(OP_SUB, 1'b0, 5'd16, 5'd22, 5'd23, '0);
                drive_lane1(OP_XOR, 1'b0, 5'd17, 5'd1, rd0, '0);
            end
            wait_accept();
        end

        go_idle();
        repeat (10) @(posedge clk);
        @(negedge clk);
        if (missing != 0) begin
            $display("%0d expected results never came out of the DUT", missing);
        end
        $display("checks done: %0d errors, %0d results missing", errors, missing);
        if (errors == 0 && missing == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
